//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_xbar
FILELIST := list.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; st=$$?; cat $(LOG); exit $$st
	@! grep -q "FAIL: see errors above" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- list.f
+incdir+verilog
verilog/xbar_pkg.sv
verilog/xbar_addr_decode.sv
verilog/xbar_src_demux.sv
verilog/xbar_dst_arbiter.sv
verilog/xbar_err_responder.sv
verilog/xbar_top.sv
tb/tb_xbar_dst_model.sv
tb/tb_xbar.sv

//--- tb/tb_xbar.sv
/*
  Testbench for the two by two crossbar.
  Runs directed and random transactions on both source ports against
  two memory models and checks each response with a reference model
  of the address map and the memories.
*/
`timescale 1ns/10ps
`include "xbar_macros.svh"

module tb_xbar import xbar_pkg::*; ();

  localparam int TIMEOUT = 200;   // Cycles per wait

  logic clk_i = 1'b0;
  logic rst_n_i;
  logic     [`XBAR_NUM_SRC-1:0]    src_req_valid_i, src_req_ready_o, src_req_we_i;
  addr_t    [`XBAR_NUM_SRC-1:0]    src_req_addr_i;
  data_t    [`XBAR_NUM_SRC-1:0]    src_req_wdata_i, src_rsp_rdata_o;
  src_id_t  [`XBAR_NUM_SRC-1:0]    src_req_id_i, src_rsp_id_o;
  logic     [`XBAR_NUM_SRC-1:0]    src_rsp_valid_o, src_rsp_ready_i, src_rsp_err_o;
  logic     [`XBAR_NUM_DST-1:0]    dst_req_valid_o, dst_req_we_o, dst_rsp_ready_o;
  addr_t    [`XBAR_NUM_DST-1:0]    dst_req_addr_o;
  data_t    [`XBAR_NUM_DST-1:0]    dst_req_wdata_o;
  dst_id_t  [`XBAR_NUM_DST-1:0]    dst_req_id_o;
  wire      [`XBAR_NUM_DST-1:0]    dst_req_ready_i, dst_rsp_valid_i, dst_rsp_err_i;
  wire data_t   [`XBAR_NUM_DST-1:0] dst_rsp_rdata_i;
  wire dst_id_t [`XBAR_NUM_DST-1:0] dst_rsp_id_i;
  addr_t    [`XBAR_NUM_RULES-1:0]  rule_start_i, rule_end_i;
  dst_idx_t [`XBAR_NUM_RULES-1:0]  rule_idx_i;
  logic     [`XBAR_NUM_SRC-1:0]    en_default_dst_i;
  dst_idx_t [`XBAR_NUM_SRC-1:0]    default_dst_i;

  int seed = 32'ha0ac;
  data_t   shadow [logic [`XBAR_ADDR_W:0]];   // Keyed by destination and address
  logic    pend_valid [`XBAR_NUM_SRC];
  int      pend_dst [`XBAR_NUM_SRC];          // -1 for a decode error
  addr_t   pend_addr [`XBAR_NUM_SRC];
  src_id_t pend_id [`XBAR_NUM_SRC];
  logic    aborted = 1'b0;
  int n_data = 0;
  int n_flag = 0;
  int n_src_id = 0;
  int n_dst_id = 0;
  int n_route = 0;
  int n_timeout = 0;

  xbar_top xbar_top_inst (.*);

  for (genvar d = 0; d < `XBAR_NUM_DST; d++) begin : gen_mem
    tb_xbar_dst_model u_mem (
      .clk_i, .rst_n_i, .dst_idx_i (dst_idx_t'(d)),
      .req_valid_i (dst_req_valid_o[d]), .req_ready_o (dst_req_ready_i[d]),
      .req_addr_i  (dst_req_addr_o[d]),  .req_wdata_i (dst_req_wdata_o[d]),
      .req_we_i    (dst_req_we_o[d]),    .req_id_i    (dst_req_id_o[d]),
      .rsp_valid_o (dst_rsp_valid_i[d]), .rsp_ready_i (dst_rsp_ready_o[d]),
      .rsp_rdata_o (dst_rsp_rdata_i[d]), .rsp_err_o   (dst_rsp_err_i[d]),
      .rsp_id_o    (dst_rsp_id_i[d])
    );
  end

  always #10 clk_i = ~clk_i;

  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp);
      n_data++;
    end
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b, expected %b", $time, what, got, exp);
      n_flag++;
    end
  endtask

  task automatic check_src_id(input string what, input src_id_t got, input src_id_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp);
      n_src_id++;
    end
  endtask

  task automatic check_dst_id(input string what, input dst_id_t got, input dst_id_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp);
      n_dst_id++;
    end
  endtask

  task automatic report_timeout(input string what, input int s);
    $display("ERROR at %0t: source %0d timed out waiting for %s", $time, s, what);
    n_timeout++;
    aborted = 1'b1;
  endtask

  // Expected routing and response, shadow memory updated on writes
  function automatic void ref_resp(input int s, input addr_t a, input logic we,
                                   input data_t wd, output int dst, output logic err,
                                   output data_t rd);
    logic [`XBAR_ADDR_W:0] key;
    dst = -1;
    for (int r = 0; r < `XBAR_NUM_RULES; r++) begin
      if (dst < 0 && a >= rule_start_i[r] && a < rule_end_i[r]) dst = int'(rule_idx_i[r]);
    end
    if (dst < 0 && en_default_dst_i[s]) dst = int'(default_dst_i[s]);
    err = (dst < 0);
    rd  = '0;
    if (dst >= 0) begin
      key = {dst[0], a};
      if (we) shadow[key] = wd;
      else if (shadow.exists(key)) rd = shadow[key];
      else rd = a ^ {8'hd0, 8'(dst), 16'h0000};   // Unwritten memory pattern
    end
  endfunction

  // Bit 2 of the address is the source index, so sources never share a word
  function automatic void random_txn(input int s, output addr_t a, output logic we,
                                     output data_t wd);
    int kind;
    kind = $random(seed) & 3;
    case (kind)
      1:       a = 32'h0000_2000;
      2:       a = 32'h0000_8000;   // Unmapped
      default: a = 32'h0000_1000;
    endcase
    a  = a | addr_t'({4'($random(seed)), 1'(s), 2'b00});
    we = 1'($random(seed));
    wd = $random(seed);
  endfunction

  task automatic do_txn(input int s, input addr_t a, input logic we, input data_t wd,
                        input src_id_t id);
    int      exp_dst;
    logic    exp_err;
    data_t   exp_rd;
    int      cnt;
    logic    hs;
    data_t   got_rd;
    logic    got_err;
    src_id_t got_id;
    if (aborted) return;
    @(posedge clk_i);
    src_req_valid_i[s] <= 1'b1;
    src_req_addr_i[s]  <= a;
    src_req_wdata_i[s] <= wd;
    src_req_we_i[s]    <= we;
    src_req_id_i[s]    <= id;
    cnt = 0;
    do begin
      @(posedge clk_i);
      hs = src_req_ready_o[s];
      cnt++;
    end while (!hs && cnt < TIMEOUT);
    src_req_valid_i[s] <= 1'b0;
    if (!hs) begin
      report_timeout("request acceptance", s);
      return;
    end
    ref_resp(s, a, we, wd, exp_dst, exp_err, exp_rd);
    pend_dst[s]   = exp_dst;
    pend_addr[s]  = a;
    pend_id[s]    = id;
    pend_valid[s] = 1'b1;
    cnt = 0;
    do begin
      @(posedge clk_i);
      hs      = src_rsp_valid_o[s];
      got_rd  = src_rsp_rdata_o[s];
      got_err = src_rsp_err_o[s];
      got_id  = src_rsp_id_o[s];
      cnt++;
    end while (!hs && cnt < TIMEOUT);
    pend_valid[s] = 1'b0;
    if (!hs) begin
      report_timeout("a response", s);
      return;
    end
    check_err("error flag", got_err, exp_err);
    check_data("read data", got_rd, exp_rd);
    check_src_id("source ID", got_id, id);
  endtask

  // Destination side monitor, checks where each request lands and its ID
  always @(posedge clk_i) begin
    int src;
    if (rst_n_i) begin
      for (int d = 0; d < `XBAR_NUM_DST; d++) begin
        if (dst_req_valid_o[d] && dst_req_ready_i[d]) begin
          src = -1;
          // Sources never have the same address in flight
          for (int s = 0; s < `XBAR_NUM_SRC; s++) begin
            if (pend_valid[s] && pend_dst[s] == d && pend_addr[s] == dst_req_addr_o[d]) begin
              src = s;
            end
          end
          if (src < 0) begin
            $display("ERROR at %0t: unexpected request at destination %0d, address %h",
                     $time, d, dst_req_addr_o[d]);
            n_route++;
          end else begin
            check_dst_id("destination ID", dst_req_id_o[d], {1'(src), pend_id[src]});
          end
        end
      end
    end
  end

  initial begin
    addr_t a0, a1;
    logic  we0, we1;
    data_t wd0, wd1;
    int    n_total;
    pend_valid       = '{default: 1'b0};
    rst_n_i          <= 1'b0;
    src_req_valid_i  <= '0;
    src_req_addr_i   <= '0;
    src_req_wdata_i  <= '0;
    src_req_we_i     <= '0;
    src_req_id_i     <= '0;
    src_rsp_ready_i  <= '1;
    rule_start_i[0]  <= 32'h0000_1000;
    rule_end_i[0]    <= 32'h0000_2000;
    rule_idx_i[0]    <= 1'b0;
    rule_start_i[1]  <= 32'h0000_2000;
    rule_end_i[1]    <= 32'h0000_3000;
    rule_idx_i[1]    <= 1'b1;
    en_default_dst_i <= '0;
    default_dst_i    <= '0;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    if (src_rsp_valid_o !== '0 || dst_req_valid_o !== '0) begin
      $display("ERROR at %0t: a valid output is high after reset", $time);
      n_flag++;
    end

    do_txn(0, 32'h0000_1010, 1'b1, 32'hcafe_0001, 4'h1);
    do_txn(0, 32'h0000_1010, 1'b0, '0, 4'h2);
    do_txn(1, 32'h0000_2024, 1'b1, 32'hcafe_0002, 4'h3);
    do_txn(1, 32'h0000_2024, 1'b0, '0, 4'h4);
    do_txn(0, 32'h0000_8000, 1'b0, '0, 4'h5);   // Decode error
    @(posedge clk_i);
    en_default_dst_i[0] <= 1'b1;
    default_dst_i[0]    <= 1'b1;
    do_txn(0, 32'h0000_8000, 1'b0, '0, 4'h6);

    // Both sources into destination 1 at once
    fork
      do_txn(0, 32'h0000_2100, 1'b1, 32'h0a0a_0a0a, 4'h7);
      do_txn(1, 32'h0000_2104, 1'b1, 32'h0b0b_0b0b, 4'h8);
    join
    fork
      do_txn(0, 32'h0000_2100, 1'b0, '0, 4'h9);
      do_txn(1, 32'h0000_2104, 1'b0, '0, 4'ha);
    join

    @(posedge clk_i);
    en_default_dst_i <= 2'b10;
    default_dst_i[1] <= 1'b0;
    for (int i = 0; i < 60; i++) begin
      random_txn(0, a0, we0, wd0);
      random_txn(1, a1, we1, wd1);
      fork
        do_txn(0, a0, we0, wd0, src_id_t'(i));
        do_txn(1, a1, we1, wd1, src_id_t'(i + 3));
      join
    end

    repeat (4) @(posedge clk_i);
    n_total = n_data + n_flag + n_src_id + n_dst_id + n_route + n_timeout;
    $display("Errors: data %0d, error flag %0d, source ID %0d, destination ID %0d, %s",
             n_data, n_flag, n_src_id, n_dst_id,
             $sformatf("routing %0d, timeout %0d", n_route, n_timeout));
    if (n_total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- tb/tb_xbar_dst_model.sv
/*
  Memory model for one destination port of the crossbar.
  Takes one request at a time and answers it a cycle later. Ready
  stalls at random, and words never written read back a pattern made
  from the address and the port index.
*/
`timescale 1ns/10ps

module tb_xbar_dst_model import xbar_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  dst_idx_t dst_idx_i,    // Port index, part of the fill pattern
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  addr_t    req_addr_i,
  input  data_t    req_wdata_i,
  input  logic     req_we_i,
  input  dst_id_t  req_id_i,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output data_t    rsp_rdata_o,
  output logic     rsp_err_o,
  output dst_id_t  rsp_id_o
);

  data_t mem [addr_t];
  int    seed = 32'ha0ac;
  logic  stall_q;

  assign req_ready_o = !rsp_valid_o && !stall_q;
  assign rsp_err_o   = 1'b0;          // Every address exists here

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
      stall_q     <= 1'b0;
    end else begin
      stall_q <= (($random(seed) & 3) == 0);   // About one cycle in four
      if (req_valid_i && req_ready_o) begin
        rsp_valid_o <= 1'b1;
        rsp_id_o    <= req_id_i;
        if (req_we_i) begin
          mem[req_addr_i] = req_wdata_i;
          rsp_rdata_o <= '0;          // Writes answer with zero data
        end else if (mem.exists(req_addr_i)) begin
          rsp_rdata_o <= mem[req_addr_i];
        end else begin
          rsp_rdata_o <= req_addr_i ^ {8'hd0, 7'b0, dst_idx_i, 16'h0000};
        end
      end else if (rsp_valid_o && rsp_ready_i) begin
        rsp_valid_o <= 1'b0;
      end
    end
  end

endmodule

//--- verilog/xbar_addr_decode.sv
/*
  Combinational address decoder, one per source port.
  Compares the request address with the rule table and gives the
  demux select: a destination index, or the error target.
*/
`timescale 1ns/10ps
`include "xbar_macros.svh"

module xbar_addr_decode import xbar_pkg::*; (
  input  addr_t                            addr_i,
  input  addr_t    [`XBAR_NUM_RULES-1:0]   rule_start_i,
  input  addr_t    [`XBAR_NUM_RULES-1:0]   rule_end_i,
  input  dst_idx_t [`XBAR_NUM_RULES-1:0]   rule_idx_i,
  input  logic                             en_default_i,
  input  dst_idx_t                         default_idx_i,
  output sel_t                             sel_o
);

  always_comb begin
    // Fallback when no rule hits
    if (en_default_i) begin
      sel_o = sel_t'(default_idx_i);
    end else begin
      sel_o = SEL_ERR;
    end

    // Walk from the highest rule down so the lowest matching rule wins
    for (int r = `XBAR_NUM_RULES - 1; r >= 0; r--) begin
      if (addr_i >= rule_start_i[r] && addr_i < rule_end_i[r]) begin // Half-open range
        sel_o = sel_t'(rule_idx_i[r]);
      end
    end
  end

endmodule

//--- verilog/xbar_dst_arbiter.sv
/*
  Destination side round-robin arbiter.
  Grants one source, registers the request with the source index put
  in front of the ID, and steers responses back by that index.
  The output register holds its contents while the destination stalls.
*/
`timescale 1ns/10ps
`include "xbar_macros.svh"

module xbar_dst_arbiter import xbar_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Requests from the source demuxes
  input  logic    [`XBAR_NUM_SRC-1:0]     req_valid_i,
  output logic    [`XBAR_NUM_SRC-1:0]     req_ready_o,
  input  addr_t   [`XBAR_NUM_SRC-1:0]     req_addr_i,
  input  data_t   [`XBAR_NUM_SRC-1:0]     req_wdata_i,
  input  logic    [`XBAR_NUM_SRC-1:0]     req_we_i,
  input  src_id_t [`XBAR_NUM_SRC-1:0]     req_id_i,
  // Responses toward the source demuxes
  output logic    [`XBAR_NUM_SRC-1:0]     rsp_valid_o,
  input  logic    [`XBAR_NUM_SRC-1:0]     rsp_ready_i,
  output data_t                           rsp_rdata_o,
  output logic                            rsp_err_o,
  output src_id_t                         rsp_id_o,
  // Destination port
  output logic                            dst_req_valid_o,
  input  logic                            dst_req_ready_i,
  output addr_t                           dst_req_addr_o,
  output data_t                           dst_req_wdata_o,
  output logic                            dst_req_we_o,
  output dst_id_t                         dst_req_id_o,
  input  logic                            dst_rsp_valid_i,
  output logic                            dst_rsp_ready_o,
  input  data_t                           dst_rsp_rdata_i,
  input  logic                            dst_rsp_err_i,
  input  dst_id_t                         dst_rsp_id_i
);

  localparam int unsigned IDX_W = $clog2(`XBAR_NUM_SRC);

  typedef logic [IDX_W-1:0] src_idx_t;

  arb_state_e state_q;
  src_idx_t   rr_q;       // Source with the highest priority
  src_idx_t   gnt_idx;
  logic       gnt_valid;
  logic       free;       // Output register can take a new request
  logic       load;
  src_idx_t   rsp_src;

  always_comb begin : grant
    src_idx_t cand;
    gnt_valid = 1'b0;
    gnt_idx   = rr_q;
    for (int unsigned k = 0; k < `XBAR_NUM_SRC; k++) begin
      cand = src_idx_t'((rr_q + k) % `XBAR_NUM_SRC);
      if (!gnt_valid && req_valid_i[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  assign free = (state_q == ARB_IDLE) || dst_req_ready_i; // Empty or draining
  assign load = gnt_valid && free;

  always_comb begin
    for (int s = 0; s < `XBAR_NUM_SRC; s++) begin
      req_ready_o[s] = load && (gnt_idx == src_idx_t'(s));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ARB_IDLE;
      rr_q    <= '0;
    end else if (load) begin
      state_q <= ARB_HOLD;
      // Priority moves to the source after the winner
      rr_q    <= (gnt_idx == src_idx_t'(`XBAR_NUM_SRC - 1)) ? '0 : gnt_idx + 1'b1;
    end else if (dst_req_ready_i) begin
      state_q <= ARB_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      dst_req_addr_o  <= req_addr_i[gnt_idx];
      dst_req_wdata_o <= req_wdata_i[gnt_idx];
      dst_req_we_o    <= req_we_i[gnt_idx];
      dst_req_id_o    <= {gnt_idx, req_id_i[gnt_idx]}; // Source index on top
    end
  end

  assign dst_req_valid_o = (state_q == ARB_HOLD);

  // Response steering by the ID prefix
  assign rsp_src = dst_rsp_id_i[`XBAR_SRC_ID_W +: IDX_W];

  always_comb begin
    for (int s = 0; s < `XBAR_NUM_SRC; s++) begin
      rsp_valid_o[s] = dst_rsp_valid_i && (rsp_src == src_idx_t'(s));
    end
  end

  assign dst_rsp_ready_o = rsp_ready_i[rsp_src];
  assign rsp_rdata_o     = dst_rsp_rdata_i;
  assign rsp_err_o       = dst_rsp_err_i;
  assign rsp_id_o        = dst_rsp_id_i[`XBAR_SRC_ID_W-1:0]; // Prefix stripped

  // Steering follows the response ID, so it must hold while the source stalls
  a_dst_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dst_rsp_valid_i && !dst_rsp_ready_o |=> dst_rsp_valid_i &&
      $stable({dst_rsp_rdata_i, dst_rsp_err_i, dst_rsp_id_i}))
    else $error("Destination response changed under back-pressure");

endmodule

//--- verilog/xbar_err_responder.sv
/*
  Decode error target, one per source port.
  Takes one request at a time and answers it a cycle later with the
  error flag set and zero read data.
*/
`timescale 1ns/10ps

module xbar_err_responder import xbar_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  src_id_t req_id_i,
  output logic    rsp_valid_o,
  input  logic    rsp_ready_i,
  output data_t   rsp_rdata_o,
  output logic    rsp_err_o,
  output src_id_t rsp_id_o
);

  logic    busy_q;
  src_id_t id_q;

  assign req_ready_o = !busy_q;    // Idle means ready
  assign rsp_valid_o = busy_q;
  assign rsp_rdata_o = '0;
  assign rsp_err_o   = 1'b1;
  assign rsp_id_o    = id_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      busy_q <= 1'b1;
    end else if (rsp_valid_o && rsp_ready_i) begin
      busy_q <= 1'b0;
    end
  end

  // ID echoed back in the response
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      id_q <= req_id_i;
    end
  end

endmodule

//--- verilog/xbar_macros.svh
/*
  Port counts, widths and rule count of the two by two crossbar.
  Included by the package and by every module that sizes its ports
  from these values.
*/
`ifndef XBAR_MACROS_SVH
`define XBAR_MACROS_SVH

`define XBAR_NUM_SRC   2   // Source ports
`define XBAR_NUM_DST   2   // Destination ports
`define XBAR_NUM_RULES 2   // Entries in the address map

`define XBAR_ADDR_W    32
`define XBAR_DATA_W    32
`define XBAR_SRC_ID_W  4   // ID width seen at a source port

`endif

//--- verilog/xbar_pkg.sv
/*
  Shared vector types of the crossbar.
  Imported by the RTL modules and by the testbench compare tasks.
*/
`include "xbar_macros.svh"

package xbar_pkg;

  typedef logic [`XBAR_ADDR_W-1:0]   addr_t;
  typedef logic [`XBAR_DATA_W-1:0]   data_t;
  typedef logic [`XBAR_SRC_ID_W-1:0] src_id_t;

  // Source index in the top bit, then the ID from the source port
  typedef logic [`XBAR_SRC_ID_W:0]   dst_id_t;

  typedef logic [$clog2(`XBAR_NUM_DST)-1:0]   dst_idx_t;
  typedef logic [$clog2(`XBAR_NUM_DST+1)-1:0] sel_t; // One more for the error target

  // Demux select that routes to the error responder
  localparam sel_t SEL_ERR = sel_t'(`XBAR_NUM_DST);

  // Arbiter output register
  typedef enum logic {
    ARB_IDLE,
    ARB_HOLD
  } arb_state_e;

endpackage

//--- verilog/xbar_src_demux.sv
/*
  Source side demultiplexer.
  Routes a request to one destination arbiter or to the error responder,
  then waits for that target's response before taking the next request.
  Target index NUM_DST is the error responder.
*/
`timescale 1ns/10ps
`include "xbar_macros.svh"

module xbar_src_demux import xbar_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Source port
  input  logic                            src_req_valid_i,
  output logic                            src_req_ready_o,
  input  addr_t                           src_req_addr_i,
  input  data_t                           src_req_wdata_i,
  input  logic                            src_req_we_i,
  input  src_id_t                         src_req_id_i,
  output logic                            src_rsp_valid_o,
  input  logic                            src_rsp_ready_i,
  output data_t                           src_rsp_rdata_o,
  output logic                            src_rsp_err_o,
  output src_id_t                         src_rsp_id_o,
  input  sel_t                            sel_i,
  // Targets
  output logic    [`XBAR_NUM_DST:0]       req_valid_o,
  input  logic    [`XBAR_NUM_DST:0]       req_ready_i,
  output addr_t                           req_addr_o,
  output data_t                           req_wdata_o,
  output logic                            req_we_o,
  output src_id_t                         req_id_o,
  input  logic    [`XBAR_NUM_DST:0]       rsp_valid_i,
  output logic    [`XBAR_NUM_DST:0]       rsp_ready_o,
  input  data_t   [`XBAR_NUM_DST:0]       rsp_rdata_i,
  input  logic    [`XBAR_NUM_DST:0]       rsp_err_i,
  input  src_id_t [`XBAR_NUM_DST:0]       rsp_id_i
);

  logic busy_q;  // One transaction in flight
  sel_t sel_q;   // Target that owes the response

  // Payload fans out to all targets, only valid is steered
  assign req_addr_o  = src_req_addr_i;
  assign req_wdata_o = src_req_wdata_i;
  assign req_we_o    = src_req_we_i;
  assign req_id_o    = src_req_id_i;

  always_comb begin
    for (int t = 0; t <= `XBAR_NUM_DST; t++) begin
      req_valid_o[t] = src_req_valid_i && !busy_q && (sel_i == sel_t'(t));
      rsp_ready_o[t] = busy_q && (sel_q == sel_t'(t)) && src_rsp_ready_i;
    end
  end

  assign src_req_ready_o = !busy_q && req_ready_i[sel_i];

  // Only the latched target may answer
  assign src_rsp_valid_o = busy_q && rsp_valid_i[sel_q];
  assign src_rsp_rdata_o = rsp_rdata_i[sel_q];
  assign src_rsp_err_o   = rsp_err_i[sel_q];
  assign src_rsp_id_o    = rsp_id_i[sel_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      sel_q  <= '0;
    end else if (src_req_valid_i && src_req_ready_o) begin
      busy_q <= 1'b1;
      sel_q  <= sel_i;
    end else if (src_rsp_valid_o && src_rsp_ready_i) begin
      busy_q <= 1'b0;
    end
  end

  // Arbiters steer by ID prefix, so no target answers unless this port asked it
  a_rsp_from_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    |rsp_valid_i |-> busy_q && (rsp_valid_i == ((`XBAR_NUM_DST+1)'(1) << sel_q)))
    else $error("Response from a target without an outstanding request");

endmodule

//--- verilog/xbar_top.sv
/*
  Crossbar top level with two source and two destination ports.
  Each source has a decoder, a demux and an error responder; each
  destination has an arbiter. Request and response channels are
  crossed between demuxes and arbiters.
*/
`timescale 1ns/10ps
`include "xbar_macros.svh"

module xbar_top import xbar_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // Source ports
  input  logic     [`XBAR_NUM_SRC-1:0]       src_req_valid_i,
  output logic     [`XBAR_NUM_SRC-1:0]       src_req_ready_o,
  input  addr_t    [`XBAR_NUM_SRC-1:0]       src_req_addr_i,
  input  data_t    [`XBAR_NUM_SRC-1:0]       src_req_wdata_i,
  input  logic     [`XBAR_NUM_SRC-1:0]       src_req_we_i,
  input  src_id_t  [`XBAR_NUM_SRC-1:0]       src_req_id_i,
  output logic     [`XBAR_NUM_SRC-1:0]       src_rsp_valid_o,
  input  logic     [`XBAR_NUM_SRC-1:0]       src_rsp_ready_i,
  output data_t    [`XBAR_NUM_SRC-1:0]       src_rsp_rdata_o,
  output logic     [`XBAR_NUM_SRC-1:0]       src_rsp_err_o,
  output src_id_t  [`XBAR_NUM_SRC-1:0]       src_rsp_id_o,
  // Destination ports
  output logic     [`XBAR_NUM_DST-1:0]       dst_req_valid_o,
  input  logic     [`XBAR_NUM_DST-1:0]       dst_req_ready_i,
  output addr_t    [`XBAR_NUM_DST-1:0]       dst_req_addr_o,
  output data_t    [`XBAR_NUM_DST-1:0]       dst_req_wdata_o,
  output logic     [`XBAR_NUM_DST-1:0]       dst_req_we_o,
  output dst_id_t  [`XBAR_NUM_DST-1:0]       dst_req_id_o,
  input  logic     [`XBAR_NUM_DST-1:0]       dst_rsp_valid_i,
  output logic     [`XBAR_NUM_DST-1:0]       dst_rsp_ready_o,
  input  data_t    [`XBAR_NUM_DST-1:0]       dst_rsp_rdata_i,
  input  logic     [`XBAR_NUM_DST-1:0]       dst_rsp_err_i,
  input  dst_id_t  [`XBAR_NUM_DST-1:0]       dst_rsp_id_i,
  // Address map
  input  addr_t    [`XBAR_NUM_RULES-1:0]     rule_start_i,
  input  addr_t    [`XBAR_NUM_RULES-1:0]     rule_end_i,
  input  dst_idx_t [`XBAR_NUM_RULES-1:0]     rule_idx_i,
  input  logic     [`XBAR_NUM_SRC-1:0]       en_default_dst_i,
  input  dst_idx_t [`XBAR_NUM_SRC-1:0]       default_dst_i
);

  // Demux side, indexed [source][target], target NUM_DST is the error responder
  logic    [`XBAR_NUM_SRC-1:0][`XBAR_NUM_DST:0] dmx_req_valid, dmx_req_ready;
  logic    [`XBAR_NUM_SRC-1:0][`XBAR_NUM_DST:0] dmx_rsp_valid, dmx_rsp_ready;
  data_t   [`XBAR_NUM_SRC-1:0][`XBAR_NUM_DST:0] dmx_rsp_rdata;
  logic    [`XBAR_NUM_SRC-1:0][`XBAR_NUM_DST:0] dmx_rsp_err;
  src_id_t [`XBAR_NUM_SRC-1:0][`XBAR_NUM_DST:0] dmx_rsp_id;
  addr_t   [`XBAR_NUM_SRC-1:0]                  dmx_req_addr;
  data_t   [`XBAR_NUM_SRC-1:0]                  dmx_req_wdata;
  logic    [`XBAR_NUM_SRC-1:0]                  dmx_req_we;
  src_id_t [`XBAR_NUM_SRC-1:0]                  dmx_req_id;

  // Arbiter side, indexed [destination][source]
  logic    [`XBAR_NUM_DST-1:0][`XBAR_NUM_SRC-1:0] arb_req_valid, arb_req_ready;
  logic    [`XBAR_NUM_DST-1:0][`XBAR_NUM_SRC-1:0] arb_rsp_valid, arb_rsp_ready;
  data_t   [`XBAR_NUM_DST-1:0]                    arb_rsp_rdata;
  logic    [`XBAR_NUM_DST-1:0]                    arb_rsp_err;
  src_id_t [`XBAR_NUM_DST-1:0]                    arb_rsp_id;

  for (genvar s = 0; s < `XBAR_NUM_SRC; s++) begin : gen_src
    sel_t sel;

    xbar_addr_decode u_decode (
      .addr_i        (src_req_addr_i[s]),
      .rule_start_i  (rule_start_i),
      .rule_end_i    (rule_end_i),
      .rule_idx_i    (rule_idx_i),
      .en_default_i  (en_default_dst_i[s]),
      .default_idx_i (default_dst_i[s]),
      .sel_o         (sel)
    );

    xbar_src_demux u_demux (
      .clk_i, .rst_n_i,
      .src_req_valid_i (src_req_valid_i[s]), .src_req_ready_o (src_req_ready_o[s]),
      .src_req_addr_i  (src_req_addr_i[s]),  .src_req_wdata_i (src_req_wdata_i[s]),
      .src_req_we_i    (src_req_we_i[s]),    .src_req_id_i    (src_req_id_i[s]),
      .src_rsp_valid_o (src_rsp_valid_o[s]), .src_rsp_ready_i (src_rsp_ready_i[s]),
      .src_rsp_rdata_o (src_rsp_rdata_o[s]), .src_rsp_err_o   (src_rsp_err_o[s]),
      .src_rsp_id_o    (src_rsp_id_o[s]),    .sel_i           (sel),
      .req_valid_o (dmx_req_valid[s]), .req_ready_i (dmx_req_ready[s]),
      .req_addr_o  (dmx_req_addr[s]),  .req_wdata_o (dmx_req_wdata[s]),
      .req_we_o    (dmx_req_we[s]),    .req_id_o    (dmx_req_id[s]),
      .rsp_valid_i (dmx_rsp_valid[s]), .rsp_ready_o (dmx_rsp_ready[s]),
      .rsp_rdata_i (dmx_rsp_rdata[s]), .rsp_err_i   (dmx_rsp_err[s]),
      .rsp_id_i    (dmx_rsp_id[s])
    );

    xbar_err_responder u_err (
      .clk_i, .rst_n_i,
      .req_valid_i (dmx_req_valid[s][`XBAR_NUM_DST]),
      .req_ready_o (dmx_req_ready[s][`XBAR_NUM_DST]),
      .req_id_i    (dmx_req_id[s]),
      .rsp_valid_o (dmx_rsp_valid[s][`XBAR_NUM_DST]),
      .rsp_ready_i (dmx_rsp_ready[s][`XBAR_NUM_DST]),
      .rsp_rdata_o (dmx_rsp_rdata[s][`XBAR_NUM_DST]),
      .rsp_err_o   (dmx_rsp_err[s][`XBAR_NUM_DST]),
      .rsp_id_o    (dmx_rsp_id[s][`XBAR_NUM_DST])
    );

    // The decode of a waiting request must not move under it
    a_default_en_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      src_req_valid_i[s] && !src_req_ready_o[s] |=> $stable(en_default_dst_i[s]))
      else $error("Default enable changed with a request waiting on source %0d", s);
    a_default_dst_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      src_req_valid_i[s] && !src_req_ready_o[s] |=> $stable(default_dst_i[s]))
      else $error("Default destination changed with a request waiting on source %0d", s);
  end

  // Cross the channels
  for (genvar s = 0; s < `XBAR_NUM_SRC; s++) begin : gen_cross_src
    for (genvar d = 0; d < `XBAR_NUM_DST; d++) begin : gen_cross_dst
      assign arb_req_valid[d][s] = dmx_req_valid[s][d];
      assign dmx_req_ready[s][d] = arb_req_ready[d][s];
      assign dmx_rsp_valid[s][d] = arb_rsp_valid[d][s];
      assign arb_rsp_ready[d][s] = dmx_rsp_ready[s][d];
      assign dmx_rsp_rdata[s][d] = arb_rsp_rdata[d];
      assign dmx_rsp_err[s][d]   = arb_rsp_err[d];
      assign dmx_rsp_id[s][d]    = arb_rsp_id[d];
    end
  end

  for (genvar d = 0; d < `XBAR_NUM_DST; d++) begin : gen_dst
    xbar_dst_arbiter u_arb (
      .clk_i, .rst_n_i,
      .req_valid_i (arb_req_valid[d]), .req_ready_o (arb_req_ready[d]),
      .req_addr_i  (dmx_req_addr),     .req_wdata_i (dmx_req_wdata),
      .req_we_i    (dmx_req_we),       .req_id_i    (dmx_req_id),
      .rsp_valid_o (arb_rsp_valid[d]), .rsp_ready_i (arb_rsp_ready[d]),
      .rsp_rdata_o (arb_rsp_rdata[d]), .rsp_err_o   (arb_rsp_err[d]),
      .rsp_id_o    (arb_rsp_id[d]),
      .dst_req_valid_o (dst_req_valid_o[d]), .dst_req_ready_i (dst_req_ready_i[d]),
      .dst_req_addr_o  (dst_req_addr_o[d]),  .dst_req_wdata_o (dst_req_wdata_o[d]),
      .dst_req_we_o    (dst_req_we_o[d]),    .dst_req_id_o    (dst_req_id_o[d]),
      .dst_rsp_valid_i (dst_rsp_valid_i[d]), .dst_rsp_ready_o (dst_rsp_ready_o[d]),
      .dst_rsp_rdata_i (dst_rsp_rdata_i[d]), .dst_rsp_err_i   (dst_rsp_err_i[d]),
      .dst_rsp_id_i    (dst_rsp_id_i[d])
    );
  end

endmodule
